// ==== src/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	localparam int NUM_REGS = 8;
	localparam int NUM_LANES = 4;

	typedef logic [2:0] reg_idx_t;
	typedef logic [NUM_LANES-1:0] lane_mask_t;
	typedef logic [NUM_LANES-1:0][31:0] vreg_t;

	// unlisted codes decode as HALT
	typedef enum logic [5:0]
	{
		ADD = 6'h00,
		SUB = 6'h01,
		AND = 6'h02,
		OR = 6'h03,
		XOR = 6'h04,
		ADDI = 6'h05,
		LOAD = 6'h06,
		STORE = 6'h07,
		BNZ = 6'h08,
		HALT = 6'h3f
	} opcode_e;

	// for LOAD and STORE, SS is one word and VV is four words
	typedef enum logic [1:0]
	{
		SS = 2'd0,
		VV = 2'd1,
		VS = 2'd2
	} operand_form_e;

	typedef struct packed
	{
		opcode_e opcode;
		operand_form_e form;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		reg_idx_t mask_reg;
		logic signed [11:0] imm;
	} instr_t;

	function automatic logic [31:0] sext_imm(logic signed [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

endpackage

// ==== src/wb_bus_pkg.sv ====
package wb_bus_pkg;

	// word addressed, no byte selects
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed
	{
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef enum logic [1:0]
	{
		IDLE,
		XFER,
		DONE
	} mem_state_e;

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
#(
	parameter logic [31:0] RESET_PC = 32'h0
)
(
	input logic clk,
	input logic rst_i,
	input logic instr_take_i,
	input logic redirect_i,
	input logic [31:0] redirect_pc_i,
	input wb_bus_pkg::wb_rsp_t bus_rsp_i,
	input logic halt_i,
	output wb_bus_pkg::wb_req_t bus_req_o,
	output cpu_isa_pkg::instr_t instr_o,
	output logic [31:0] pc_o,
	output logic instr_valid_o
);
	import cpu_isa_pkg::*;

	logic [31:0] fetch_pc_q;
	logic [31:0] adr_q;
	logic pending_q;
	logic buf_valid_q;
	instr_t buf_instr_q;
	logic [31:0] buf_pc_q;
	logic issue;
	logic keep_data;
	logic [31:0] cur_adr;

	// start when the buffer is empty or being taken this cycle
	assign issue = !pending_q && !halt_i && (!buf_valid_q || instr_take_i);

	always_comb
	begin
		if (pending_q)
			cur_adr = adr_q;
		else if (redirect_i)
			cur_adr = redirect_pc_i;
		else
			cur_adr = fetch_pc_q;
	end

	// a fetch is only in flight while the buffer is empty
	assign keep_data = bus_rsp_i.ack;

	always_comb
	begin
		bus_req_o.cyc = pending_q || issue;
		bus_req_o.stb = pending_q || issue;
		bus_req_o.we = 1'b0;
		bus_req_o.adr = cur_adr;
		bus_req_o.dat = '0;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			fetch_pc_q <= RESET_PC;
			pending_q <= 1'b0;
			buf_valid_q <= 1'b0;
		end
		else
		begin
			if (issue)
				fetch_pc_q <= cur_adr + 32'd1;
			else if (redirect_i)
				fetch_pc_q <= redirect_pc_i;

			if (bus_rsp_i.ack)
				pending_q <= 1'b0;
			else if (issue)
				pending_q <= 1'b1;

			if (keep_data)
				buf_valid_q <= 1'b1;
			else if (instr_take_i || redirect_i)
				buf_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			adr_q <= cur_adr;
		if (keep_data)
		begin
			buf_instr_q <= instr_t'(bus_rsp_i.dat);
			buf_pc_q <= cur_adr;
		end
	end

	assign instr_o = buf_instr_q;
	assign pc_o = buf_pc_q;
	assign instr_valid_o = buf_valid_q;

endmodule

// ==== src/register_bank.sv ====
`timescale 1ns/1ps

module register_bank
(
	input logic clk,
	input logic rst_i,
	input cpu_isa_pkg::reg_idx_t s_rd1_i,
	input cpu_isa_pkg::reg_idx_t s_rd2_i,
	input cpu_isa_pkg::reg_idx_t s_mask_rd_i,
	input cpu_isa_pkg::reg_idx_t v_rd1_i,
	input cpu_isa_pkg::reg_idx_t v_rd2_i,
	input logic s_we_i,
	input logic v_we_i,
	input cpu_isa_pkg::reg_idx_t wr_reg_i,
	input logic [31:0] s_wr_data_i,
	input cpu_isa_pkg::vreg_t v_wr_data_i,
	input cpu_isa_pkg::lane_mask_t lane_mask_i,
	output logic [31:0] s_rd1_o,
	output logic [31:0] s_rd2_o,
	output logic [31:0] s_mask_o,
	output cpu_isa_pkg::vreg_t v_rd1_o,
	output cpu_isa_pkg::vreg_t v_rd2_o
);
	import cpu_isa_pkg::*;

	logic [31:0] s_regs [NUM_REGS];
	vreg_t v_regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int r = 0; r < NUM_REGS; r++)
			begin
				s_regs[r] <= '0;
				v_regs[r] <= '0;
			end
		end
		else
		begin
			if (s_we_i)
				s_regs[wr_reg_i] <= s_wr_data_i;
			// disabled lanes keep their old value
			if (v_we_i)
			begin
				for (int l = 0; l < NUM_LANES; l++)
				begin
					if (lane_mask_i[l])
						v_regs[wr_reg_i][l] <= v_wr_data_i[l];
				end
			end
		end
	end

	assign s_rd1_o = s_regs[s_rd1_i];
	assign s_rd2_o = s_regs[s_rd2_i];
	assign s_mask_o = s_regs[s_mask_rd_i];
	assign v_rd1_o = v_regs[v_rd1_i];
	assign v_rd2_o = v_regs[v_rd2_i];

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit
(
	input logic clk,
	input logic rst_i,
	input cpu_isa_pkg::instr_t instr_i,
	input logic [31:0] pc_i,
	input logic instr_valid_i,
	input logic [31:0] s_rd1_data_i,
	input logic [31:0] s_rd2_data_i,
	input logic [31:0] s_mask_data_i,
	input cpu_isa_pkg::vreg_t v_rd1_data_i,
	input cpu_isa_pkg::vreg_t v_rd2_data_i,
	input logic mem_done_i,
	input cpu_isa_pkg::vreg_t load_data_i,
	output logic instr_take_o,
	output logic redirect_o,
	output logic [31:0] redirect_pc_o,
	output cpu_isa_pkg::reg_idx_t s_rd1_sel_o,
	output cpu_isa_pkg::reg_idx_t s_rd2_sel_o,
	output cpu_isa_pkg::reg_idx_t s_mask_sel_o,
	output cpu_isa_pkg::reg_idx_t v_rd1_sel_o,
	output cpu_isa_pkg::reg_idx_t v_rd2_sel_o,
	output logic s_we_o,
	output logic v_we_o,
	output cpu_isa_pkg::reg_idx_t wr_reg_o,
	output logic [31:0] s_wr_data_o,
	output cpu_isa_pkg::vreg_t v_wr_data_o,
	output cpu_isa_pkg::lane_mask_t lane_mask_o,
	output logic mem_start_o,
	output logic mem_write_o,
	output logic mem_vector_o,
	output logic [31:0] mem_addr_o,
	output cpu_isa_pkg::vreg_t store_data_o,
	output logic halted_o
);
	import cpu_isa_pkg::*;

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_MEM_WAIT,
		S_HALTED
	} ex_state_e;

	ex_state_e state_q;
	ex_state_e state_d;
	logic [31:0] imm_ext;
	logic [31:0] s_alu;
	vreg_t v_alu;

	function automatic logic [31:0] alu(opcode_e op, logic [31:0] a, logic [31:0] b);
		case (op)
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			default: return a + b;
		endcase
	endfunction

	assign imm_ext = sext_imm(instr_i.imm);
	assign s_alu = alu(instr_i.opcode, s_rd1_data_i, s_rd2_data_i);

	// VS broadcasts scalar src2 into every lane
	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
			v_alu[l] = alu(instr_i.opcode, v_rd1_data_i[l],
				(instr_i.form == VS) ? s_rd2_data_i : v_rd2_data_i[l]);
	end

	assign s_rd1_sel_o = instr_i.src1;
	assign s_rd2_sel_o = instr_i.src2;
	assign s_mask_sel_o = instr_i.mask_reg;
	assign v_rd1_sel_o = instr_i.src1;
	assign v_rd2_sel_o = instr_i.src2;
	assign wr_reg_o = instr_i.dst;
	assign lane_mask_o = (instr_i.mask_reg == '0) ? '1 : s_mask_data_i[NUM_LANES-1:0];

	always_comb
	begin
		case (instr_i.opcode)
			LOAD: s_wr_data_o = load_data_i[0];
			ADDI: s_wr_data_o = s_rd1_data_i + imm_ext;
			default: s_wr_data_o = s_alu;
		endcase
	end
	assign v_wr_data_o = (instr_i.opcode == LOAD) ? load_data_i : v_alu;

	assign redirect_pc_o = pc_i + imm_ext;
	assign mem_addr_o = s_rd1_data_i + imm_ext;
	assign mem_write_o = (instr_i.opcode == STORE);
	assign mem_vector_o = (instr_i.form == VV);

	always_comb
	begin
		store_data_o = v_rd2_data_i;
		if (!mem_vector_o)
		begin
			store_data_o = '0;
			store_data_o[0] = s_rd2_data_i;
		end
	end

	always_comb
	begin
		state_d = state_q;
		instr_take_o = 1'b0;
		redirect_o = 1'b0;
		s_we_o = 1'b0;
		v_we_o = 1'b0;
		mem_start_o = 1'b0;
		case (state_q)
			S_IDLE:
				if (instr_valid_i)
				begin
					case (instr_i.opcode)
						ADD, SUB, AND, OR, XOR:
						begin
							instr_take_o = 1'b1;
							s_we_o = (instr_i.form == SS);
							v_we_o = (instr_i.form != SS);
						end
						ADDI:
						begin
							instr_take_o = 1'b1;
							s_we_o = 1'b1;
						end
						LOAD, STORE:
						begin
							mem_start_o = 1'b1;
							state_d = S_MEM_WAIT;
						end
						BNZ:
						begin
							instr_take_o = 1'b1;
							redirect_o = (s_rd1_data_i != '0);
						end
						// halt stays in the buffer so fetch stalls behind it
						default:
							state_d = S_HALTED;
					endcase
				end
			S_MEM_WAIT:
				if (mem_done_i)
				begin
					instr_take_o = 1'b1;
					s_we_o = (instr_i.opcode == LOAD) && !mem_vector_o;
					v_we_o = (instr_i.opcode == LOAD) && mem_vector_o;
					state_d = S_IDLE;
				end
			default:
				state_d = S_HALTED;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			state_q <= S_IDLE;
		else
			state_q <= state_d;
	end

	assign halted_o = (state_q == S_HALTED);

endmodule

// ==== src/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit
(
	input logic clk,
	input logic rst_i,
	input logic mem_start_i,
	input logic mem_write_i,
	input logic mem_vector_i,
	input logic [31:0] mem_addr_i,
	input cpu_isa_pkg::vreg_t store_data_i,
	output logic mem_done_o,
	output cpu_isa_pkg::vreg_t load_data_o,
	output wb_bus_pkg::wb_req_t bus_req_o,
	input wb_bus_pkg::wb_rsp_t bus_rsp_i
);
	import cpu_isa_pkg::*;
	import wb_bus_pkg::*;

	localparam int LANE_W = $clog2(NUM_LANES);

	mem_state_e state_q;
	logic [LANE_W-1:0] lane_q;
	logic [LANE_W-1:0] last_lane;
	logic [31:0] base_q;
	logic write_q;
	logic vector_q;
	vreg_t store_q;
	vreg_t load_q;
	logic xfer;

	assign xfer = (state_q == XFER);
	assign last_lane = vector_q ? LANE_W'(NUM_LANES - 1) : '0;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= IDLE;
			lane_q <= '0;
		end
		else
		begin
			case (state_q)
				IDLE:
					if (mem_start_i)
					begin
						state_q <= XFER;
						lane_q <= '0;
					end
				// next lane goes out right after the ack
				XFER:
					if (bus_rsp_i.ack)
					begin
						if (lane_q == last_lane)
							state_q <= DONE;
						else
							lane_q <= lane_q + 1'b1;
					end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state_q == IDLE && mem_start_i)
		begin
			base_q <= mem_addr_i;
			write_q <= mem_write_i;
			vector_q <= mem_vector_i;
			store_q <= store_data_i;
		end
		if (xfer && bus_rsp_i.ack && !write_q)
			load_q[lane_q] <= bus_rsp_i.dat;
	end

	always_comb
	begin
		bus_req_o.cyc = xfer;
		bus_req_o.stb = xfer;
		bus_req_o.we = xfer && write_q;
		bus_req_o.adr = base_q + 32'(lane_q);
		bus_req_o.dat = store_q[lane_q];
	end

	assign mem_done_o = (state_q == DONE);
	assign load_data_o = load_q;

endmodule

// ==== src/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter
(
	input logic clk,
	input logic rst_i,
	input wb_bus_pkg::wb_req_t data_req_i,
	input wb_bus_pkg::wb_req_t fetch_req_i,
	input wb_bus_pkg::wb_rsp_t bus_rsp_i,
	output wb_bus_pkg::wb_rsp_t data_rsp_o,
	output wb_bus_pkg::wb_rsp_t fetch_rsp_o,
	output wb_bus_pkg::wb_req_t bus_req_o
);
	typedef enum logic [1:0]
	{
		OWN_NONE,
		OWN_DATA,
		OWN_FETCH
	} owner_e;

	owner_e owner_q;
	owner_e grant;

	// data wins when the port is free
	always_comb
	begin
		if (owner_q != OWN_NONE)
			grant = owner_q;
		else if (data_req_i.cyc && data_req_i.stb)
			grant = OWN_DATA;
		else if (fetch_req_i.cyc && fetch_req_i.stb)
			grant = OWN_FETCH;
		else
			grant = OWN_NONE;
	end

	// held until the ack, then arbitrate again
	always_ff @(posedge clk)
	begin
		if (rst_i)
			owner_q <= OWN_NONE;
		else if (bus_rsp_i.ack)
			owner_q <= OWN_NONE;
		else
			owner_q <= grant;
	end

	always_comb
	begin
		case (grant)
			OWN_DATA: bus_req_o = data_req_i;
			OWN_FETCH: bus_req_o = fetch_req_i;
			default: bus_req_o = '0;
		endcase
	end

	assign data_rsp_o.ack = bus_rsp_i.ack && (grant == OWN_DATA);
	assign data_rsp_o.dat = bus_rsp_i.dat;
	assign fetch_rsp_o.ack = bus_rsp_i.ack && (grant == OWN_FETCH);
	assign fetch_rsp_o.dat = bus_rsp_i.dat;

endmodule

// ==== src/vector_core.sv ====
`timescale 1ns/1ps

module vector_core
#(
	parameter logic [31:0] RESET_PC = 32'h0
)
(
	input logic clk,
	input logic rst_i,
	input wb_bus_pkg::wb_rsp_t wb_rsp_i,
	output wb_bus_pkg::wb_req_t wb_req_o,
	output logic halted_o
);
	import cpu_isa_pkg::*;
	import wb_bus_pkg::*;

	instr_t instr;
	logic [31:0] pc;
	logic [31:0] redirect_pc;
	logic instr_valid;
	logic instr_take;
	logic redirect;
	reg_idx_t s_rd1_sel;
	reg_idx_t s_rd2_sel;
	reg_idx_t s_mask_sel;
	reg_idx_t v_rd1_sel;
	reg_idx_t v_rd2_sel;
	reg_idx_t wr_reg;
	logic [31:0] s_rd1_data;
	logic [31:0] s_rd2_data;
	logic [31:0] s_mask_data;
	logic [31:0] s_wr_data;
	vreg_t v_rd1_data;
	vreg_t v_rd2_data;
	vreg_t v_wr_data;
	vreg_t store_data;
	vreg_t load_data;
	lane_mask_t lane_mask;
	logic s_we;
	logic v_we;
	logic mem_start;
	logic mem_write;
	logic mem_vector;
	logic mem_done;
	logic [31:0] mem_addr;
	wb_req_t fetch_req;
	wb_req_t data_req;
	wb_rsp_t fetch_rsp;
	wb_rsp_t data_rsp;

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .rst_i(rst_i),
		.instr_take_i(instr_take), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.bus_rsp_i(fetch_rsp), .halt_i(halted_o), .bus_req_o(fetch_req),
		.instr_o(instr), .pc_o(pc), .instr_valid_o(instr_valid));

	register_bank u_regs (
		.clk(clk), .rst_i(rst_i),
		.s_rd1_i(s_rd1_sel), .s_rd2_i(s_rd2_sel), .s_mask_rd_i(s_mask_sel),
		.v_rd1_i(v_rd1_sel), .v_rd2_i(v_rd2_sel),
		.s_we_i(s_we), .v_we_i(v_we), .wr_reg_i(wr_reg),
		.s_wr_data_i(s_wr_data), .v_wr_data_i(v_wr_data), .lane_mask_i(lane_mask),
		.s_rd1_o(s_rd1_data), .s_rd2_o(s_rd2_data), .s_mask_o(s_mask_data),
		.v_rd1_o(v_rd1_data), .v_rd2_o(v_rd2_data));

	execute_unit u_execute (
		.clk(clk), .rst_i(rst_i),
		.instr_i(instr), .pc_i(pc), .instr_valid_i(instr_valid),
		.s_rd1_data_i(s_rd1_data), .s_rd2_data_i(s_rd2_data), .s_mask_data_i(s_mask_data),
		.v_rd1_data_i(v_rd1_data), .v_rd2_data_i(v_rd2_data),
		.mem_done_i(mem_done), .load_data_i(load_data),
		.instr_take_o(instr_take), .redirect_o(redirect), .redirect_pc_o(redirect_pc),
		.s_rd1_sel_o(s_rd1_sel), .s_rd2_sel_o(s_rd2_sel), .s_mask_sel_o(s_mask_sel),
		.v_rd1_sel_o(v_rd1_sel), .v_rd2_sel_o(v_rd2_sel),
		.s_we_o(s_we), .v_we_o(v_we), .wr_reg_o(wr_reg),
		.s_wr_data_o(s_wr_data), .v_wr_data_o(v_wr_data), .lane_mask_o(lane_mask),
		.mem_start_o(mem_start), .mem_write_o(mem_write), .mem_vector_o(mem_vector),
		.mem_addr_o(mem_addr), .store_data_o(store_data), .halted_o(halted_o));

	load_store_unit u_lsu (
		.clk(clk), .rst_i(rst_i),
		.mem_start_i(mem_start), .mem_write_i(mem_write), .mem_vector_i(mem_vector),
		.mem_addr_i(mem_addr), .store_data_i(store_data),
		.mem_done_o(mem_done), .load_data_o(load_data),
		.bus_req_o(data_req), .bus_rsp_i(data_rsp));

	wb_arbiter u_arbiter (
		.clk(clk), .rst_i(rst_i),
		.data_req_i(data_req), .fetch_req_i(fetch_req), .bus_rsp_i(wb_rsp_i),
		.data_rsp_o(data_rsp), .fetch_rsp_o(fetch_rsp), .bus_req_o(wb_req_o));

endmodule

// ==== tb/vector_core_assert.sv ====
`timescale 1ns/1ps

module vector_core_assert
(
	input logic clk,
	input logic rst_i,
	input wb_bus_pkg::wb_req_t wb_req_i,
	input wb_bus_pkg::wb_rsp_t wb_rsp_i,
	input logic halted_i
);

	stb_needs_cyc: assert property (@(posedge clk) disable iff (rst_i)
		wb_req_i.stb |-> wb_req_i.cyc)
		else $error("stb asserted without cyc");

	// request is frozen until the slave acks
	req_held: assert property (@(posedge clk) disable iff (rst_i)
		wb_req_i.stb && !wb_rsp_i.ack |=> wb_req_i.stb && $stable(wb_req_i.adr)
			&& $stable(wb_req_i.we) && $stable(wb_req_i.dat))
		else $error("bus request changed before ack");

	halt_sticky: assert property (@(posedge clk) disable iff (rst_i)
		halted_i |=> halted_i)
		else $error("halted dropped without reset");

	no_stb_halted: assert property (@(posedge clk) disable iff (rst_i)
		halted_i && !wb_req_i.stb |=> !wb_req_i.stb)
		else $error("new bus strobe after halt");

endmodule

bind vector_core vector_core_assert u_assert (
	.clk(clk), .rst_i(rst_i), .wb_req_i(wb_req_o), .wb_rsp_i(wb_rsp_i), .halted_i(halted_o));

// ==== tb/tb_vector_core.sv ====
`timescale 1ns/1ps

module tb_vector_core;
	import cpu_isa_pkg::*;
	import wb_bus_pkg::*;

	localparam int NUM_TESTS = 6;
	// each program halts well inside 3000 cycles even with 3 wait states per transfer
	localparam int MAX_CYCLES = NUM_TESTS * 3000 + 2000;

	logic clk;
	logic rst_i;
	wb_rsp_t wb_rsp;
	wb_req_t wb_req;
	logic halted;

	logic [31:0] mem [256];
	logic [31:0] ref_mem [256];
	logic [31:0] seed;
	logic [31:0] rnd;
	int load_ptr;
	int cycles;
	int errors;
	int checks;
	int test_errors;
	string test_name;
	logic compare_req;
	wb_req_t req_s;
	logic rst_s;
	logic ack_s;
	logic started;
	logic [1:0] wait_cnt;

	vector_core #(.RESET_PC(32'h0)) u_vector_core (
		.clk(clk), .rst_i(rst_i), .wb_rsp_i(wb_rsp), .wb_req_o(wb_req), .halted_o(halted));

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] encode(opcode_e op, operand_form_e f, int d, int s1, int s2,
		int mk, int imm);
		return {op, f, 3'(d), 3'(s1), 3'(s2), 3'(mk), 12'(imm)};
	endfunction

	function automatic logic [31:0] ref_alu(logic [5:0] op, logic [31:0] a, logic [31:0] b);
		case (op)
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			default: return a + b;
		endcase
	endfunction

	// walks the program in ref_mem the way the ISA defines it
	function automatic void run_reference();
		logic [31:0] sr [8];
		logic [31:0] vr [8][4];
		logic [31:0] w;
		logic [31:0] pc;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [5:0] op;
		logic [1:0] form;
		logic [2:0] d;
		logic [2:0] s1;
		logic [2:0] s2;
		logic [2:0] mk;
		logic [3:0] lm;
		logic running;
		int steps;
		for (int r = 0; r < 8; r++)
		begin
			sr[r] = '0;
			for (int l = 0; l < 4; l++)
				vr[r][l] = '0;
		end
		pc = '0;
		running = 1'b1;
		steps = 0;
		while (running && steps < 2000)
		begin
			w = ref_mem[pc[7:0]];
			op = w[31:26];
			form = w[25:24];
			d = w[23:21];
			s1 = w[20:18];
			s2 = w[17:15];
			mk = w[14:12];
			imm = {{20{w[11]}}, w[11:0]};
			lm = (mk == 3'd0) ? 4'hf : sr[mk][3:0];
			addr = sr[s1] + imm;
			steps++;
			pc = pc + 32'd1;
			case (op)
				ADD, SUB, AND, OR, XOR:
					if (form == 2'd0)
						sr[d] = ref_alu(op, sr[s1], sr[s2]);
					else
						for (int l = 0; l < 4; l++)
							if (lm[l])
								vr[d][l] = ref_alu(op, vr[s1][l], (form == 2'd2) ? sr[s2] : vr[s2][l]);
				ADDI: sr[d] = sr[s1] + imm;
				LOAD:
					if (form == 2'd1)
					begin
						for (int l = 0; l < 4; l++)
							if (lm[l])
								vr[d][l] = ref_mem[8'(addr + 32'(l))];
					end
					else
						sr[d] = ref_mem[addr[7:0]];
				STORE:
					if (form == 2'd1)
					begin
						for (int l = 0; l < 4; l++)
							ref_mem[8'(addr + 32'(l))] = vr[s2][l];
					end
					else
						ref_mem[addr[7:0]] = sr[s2];
				BNZ:
					if (sr[s1] != '0)
						pc = pc - 32'd1 + imm;
				default: running = 1'b0;
			endcase
		end
	endfunction

	task automatic put(int a, logic [31:0] w);
		mem[a] = w;
		ref_mem[a] = w;
	endtask

	task automatic emit(logic [31:0] w);
		put(load_ptr, w);
		load_ptr++;
	endtask

	task automatic fill_memory();
		for (int a = 0; a < 256; a++)
			put(a, {8'(a), 8'(~a), 8'(a * 3), 8'h5a});
		load_ptr = 0;
	endtask

	task automatic load_program(int t);
		case (t)
			0:
			begin
				test_name = "scalar_alu";
				emit(encode(ADDI, SS, 1, 0, 0, 0, 100));
				emit(encode(ADDI, SS, 2, 0, 0, 0, -7));
				emit(encode(ADD, SS, 3, 1, 2, 0, 0));
				emit(encode(SUB, SS, 4, 1, 2, 0, 0));
				emit(encode(AND, SS, 5, 3, 4, 0, 0));
				emit(encode(OR, SS, 6, 3, 4, 0, 0));
				emit(encode(XOR, SS, 7, 5, 6, 0, 0));
				emit(encode(ADDI, SS, 1, 0, 0, 0, 'h90));
				for (int r = 3; r < 8; r++)
					emit(encode(STORE, SS, 0, 1, r, 0, r - 3));
			end
			1:
			begin
				test_name = "vector_forms";
				emit(encode(ADDI, SS, 1, 0, 0, 0, 'h80));
				emit(encode(ADDI, SS, 2, 0, 0, 0, 'h55));
				emit(encode(LOAD, VV, 1, 1, 0, 0, 0));
				emit(encode(LOAD, VV, 2, 1, 0, 0, 4));
				emit(encode(ADD, VV, 3, 1, 2, 0, 0));
				emit(encode(SUB, VV, 4, 1, 2, 0, 0));
				emit(encode(XOR, VS, 5, 1, 2, 0, 0));
				emit(encode(STORE, VV, 0, 1, 3, 0, 32));
				emit(encode(STORE, VV, 0, 1, 4, 0, 36));
				emit(encode(STORE, VV, 0, 1, 5, 0, 40));
			end
			2:
			begin
				test_name = "lane_mask";
				emit(encode(ADDI, SS, 1, 0, 0, 0, 'h80));
				emit(encode(ADDI, SS, 3, 0, 0, 0, 5));
				emit(encode(LOAD, VV, 1, 1, 0, 0, 0));
				emit(encode(LOAD, VV, 2, 1, 0, 3, 4));
				emit(encode(ADD, VV, 1, 1, 2, 3, 0));
				emit(encode(ADD, VV, 4, 2, 2, 0, 0));
				// r4 is zero, so no lane is enabled
				emit(encode(XOR, VV, 2, 1, 1, 4, 0));
				emit(encode(STORE, VV, 0, 1, 1, 0, 32));
				emit(encode(STORE, VV, 0, 1, 4, 0, 36));
				emit(encode(STORE, VV, 0, 1, 2, 0, 40));
			end
			3:
			begin
				test_name = "bnz_loop";
				emit(encode(ADDI, SS, 1, 0, 0, 0, 'h80));
				emit(encode(ADDI, SS, 2, 0, 0, 0, 8));
				emit(encode(LOAD, SS, 4, 1, 0, 0, 0));
				emit(encode(ADD, SS, 3, 3, 4, 0, 0));
				emit(encode(ADDI, SS, 1, 1, 0, 0, 1));
				emit(encode(ADDI, SS, 2, 2, 0, 0, -1));
				emit(encode(BNZ, SS, 0, 2, 0, 0, -4));
				emit(encode(STORE, SS, 0, 0, 3, 0, 'hc0));
			end
			4:
			begin
				test_name = "mixed_memory";
				for (int i = 0; i < 16; i++)
					put('h80 + i, lcg_next());
				emit(encode(ADDI, SS, 1, 0, 0, 0, 'h80));
				emit(encode(LOAD, VV, 1, 1, 0, 0, 0));
				emit(encode(LOAD, SS, 2, 1, 0, 0, 5));
				emit(encode(STORE, VV, 0, 1, 1, 0, 32));
				emit(encode(ADD, VS, 2, 1, 2, 0, 0));
				emit(encode(STORE, VV, 0, 1, 2, 0, 36));
				emit(encode(LOAD, VV, 3, 1, 0, 0, 34));
				emit(encode(STORE, SS, 0, 1, 2, 0, 48));
				emit(encode(STORE, VV, 0, 1, 3, 0, 40));
			end
			default:
			begin
				test_name = "halt";
				emit(encode(ADDI, SS, 1, 0, 0, 0, 7));
				emit(encode(STORE, SS, 0, 0, 1, 0, 'hd0));
				emit(encode(HALT, SS, 0, 0, 0, 0, 0));
				// never reached
				emit(encode(STORE, SS, 0, 0, 1, 0, 'hd1));
			end
		endcase
		emit(encode(HALT, SS, 0, 0, 0, 0, 0));
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#1 rst_i = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst_i = 1'b0;
	endtask

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			$display("Mismatch %s: expected %h actual %h", name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	// Wishbone slave with 0 to 3 wait cycles per strobe
	always @(posedge clk)
	begin
		req_s = wb_req;
		rst_s = rst_i;
		ack_s = wb_rsp.ack;
		#1;
		if (rst_s || ack_s)
		begin
			wb_rsp.ack = 1'b0;
			started = 1'b0;
		end
		else if (req_s.cyc && req_s.stb)
		begin
			if (!started)
			begin
				started = 1'b1;
				rnd = lcg_next();
				wait_cnt = rnd[31:30];
			end
			if (wait_cnt == 2'd0)
			begin
				if (req_s.we)
					mem[req_s.adr[7:0]] = req_s.dat;
				else
					wb_rsp.dat = mem[req_s.adr[7:0]];
				wb_rsp.ack = 1'b1;
			end
			else
				wait_cnt = wait_cnt - 2'd1;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: core did not halt within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	initial
	begin
		wait (compare_req === 1'b0);
		forever
		begin
			wait (compare_req);
			for (int a = 0; a < 256; a++)
				check_value($sformatf("%s word %02h", test_name, a), ref_mem[a], mem[a]);
			check_value({test_name, " halted"}, 32'd1, {31'b0, halted});
			compare_req = 1'b0;
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_i = 1'b1;
		wb_rsp = '0;
		seed = 32'ha526_f420;
		cycles = 0;
		errors = 0;
		checks = 0;
		started = 1'b0;
		compare_req = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			test_errors = 0;
			fill_memory();
			load_program(t);
			run_reference();
			pulse_reset();
			while (!halted)
			begin
				@(posedge clk);
				#1;
			end
			repeat (20) @(posedge clk);
			#1 compare_req = 1'b1;
			wait (!compare_req);
			$display("test %0d %s finished with %0d errors", t, test_name, test_errors);
		end
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== vector_core.f ====
src/cpu_isa_pkg.sv
src/wb_bus_pkg.sv
src/fetch_unit.sv
src/register_bank.sv
src/execute_unit.sv
src/load_store_unit.sv
src/wb_arbiter.sv
src/vector_core.sv
tb/vector_core_assert.sv
tb/tb_vector_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vector_core \
	-f vector_core.f -o sim_vector_core > build.log 2>&1 \
	&& ./obj_dir/sim_vector_core > sim.log 2>&1 \
	|| { echo "build or simulation failed"; exit 1; }

grep -q "^Done: no errors$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
